// ==== filelist.f ====
+incdir+.
eth_pkg.sv
eth_dp_ram.sv
eth_crc32.sv
eth_regs.sv
eth_phy_rst.sv
eth_tx.sv
eth_rx.sv
eth_core.sv
eth_assert.sv
tb_eth.sv

// ==== Bender.yml ====
package:
  name: eth_mac

sources:
  - include_dirs:
      - .
    files:
      - eth_pkg.sv
      - eth_dp_ram.sv
      - eth_crc32.sv
      - eth_regs.sv
      - eth_phy_rst.sv
      - eth_tx.sv
      - eth_rx.sv
      - eth_core.sv
  - target: test
    include_dirs:
      - .
    files:
      - eth_assert.sv
      - tb_eth.sv

// ==== tb_eth.sv ====
`default_nettype none

`include "eth_params.svh"

module tb_eth
   import eth_pkg::*;
();

   localparam int MAX_LEN = 200;
   localparam int FRAME_CYCLES = 16 + 2 * MAX_LEN + 8;
   // payload writes, buffer reads and polls around each frame
   localparam int HOST_CYCLES = 8 * MAX_LEN;
   localparam int N_FRAMES = 8;
   localparam int WATCHDOG_CYCLES = N_FRAMES * (FRAME_CYCLES + HOST_CYCLES)
                                    + 4 * (`ETH_PHY_RST_CYCLES + 64);
   localparam int POLL_LIMIT = FRAME_CYCLES + 64;

   logic clk;
   logic rst_int;
   logic sel;
   logic we;
   eth_reg_addr_t addr;
   logic [31:0] data_in;
   logic [31:0] data_out;
   logic tx_en;
   logic [3:0] tx_data;
   logic rx_dv;
   logic [3:0] rx_data;
   logic phy_resetn;
   logic loop_en;
   logic drv_dv;
   logic [3:0] drv_data;
   logic [31:0] lfsr;
   eth_byte_t payload [MAX_LEN];
   logic [3:0] mon_q [$];
   int frame_len;
   int errors;
   int tests;
   int tests_ok;

   // mii loopback unless a test drives the receive side itself
   assign rx_dv = loop_en ? tx_en : drv_dv;
   assign rx_data = loop_en ? tx_data : drv_data;

   eth_core dut (
      .clk(clk),
      .rst_int(rst_int),
      .sel(sel),
      .we(we),
      .addr(addr),
      .data_in(data_in),
      .data_out(data_out),
      .tx_en(tx_en),
      .tx_data(tx_data),
      .rx_dv(rx_dv),
      .rx_data(rx_data),
      .phy_resetn(phy_resetn)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // nibble monitor on the transmit side
   always @(negedge clk) begin
      if (tx_en) begin
         mon_q.push_back(tx_data);
      end
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("watchdog expired after %0d cycles, the run did not complete", WATCHDOG_CYCLES);
      $display("TEST FAILED");
      $finish;
   end

   // fibonacci lfsr on taps 32 22 2 1
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
         r = {r[30:0], lfsr[0]};
      end
      return r;
   endfunction

   task automatic compare_word(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
      if (got !== exp) begin
         $display("Mismatch %s: got 0x%08h expected 0x%08h", name, got, exp);
         errors++;
      end
   endtask

   task automatic compare_byte(input string name, input eth_byte_t got, input eth_byte_t exp);
      if (got !== exp) begin
         $display("Mismatch %s: got 0x%02h expected 0x%02h", name, got, exp);
         errors++;
      end
   endtask

   task automatic compare_crc(input string name, input eth_crc_t got, input eth_crc_t exp);
      if (got !== exp) begin
         $display("Mismatch %s: got 0x%08h expected 0x%08h", name, got, exp);
         errors++;
      end
   endtask

   task automatic host_write(input eth_reg_addr_t a, input logic [31:0] d);
      @(posedge clk);
      sel <= 1'b1;
      we <= 1'b1;
      addr <= a;
      data_in <= d;
      @(posedge clk);
      sel <= 1'b0;
      we <= 1'b0;
   endtask

   task automatic host_read(input eth_reg_addr_t a, output logic [31:0] d);
      @(posedge clk);
      sel <= 1'b1;
      we <= 1'b0;
      addr <= a;
      @(posedge clk);
      sel <= 1'b0;
      @(negedge clk);
      d = data_out;
   endtask

   task automatic wait_status(input int bit_idx, input int limit, input string label);
      logic [31:0] st;
      int cycles;
      st = '0;
      cycles = 0;
      while (st[bit_idx] !== 1'b1 && cycles < limit) begin
         host_read(`ETH_STATUS, st);
         cycles += 2;
      end
      if (st[bit_idx] !== 1'b1) begin
         $display("timeout after %0d cycles waiting for %s", cycles, label);
         errors++;
      end
   endtask

   task automatic send_frame(input int n, input bit set_counts);
      for (int i = 0; i < n; i++) begin
         payload[i] = eth_byte_t'(rand_bits(8));
         host_write(eth_reg_addr_t'(12'h800 + i), {24'd0, payload[i]});
      end
      if (set_counts) begin
         host_write(`ETH_TX_NBYTES, n);
         host_write(`ETH_RX_NBYTES, n);
      end
      frame_len = n;
      wait_status(0, POLL_LIMIT, "ready");
      mon_q.delete();
      host_write(`ETH_SEND, 32'd1);
      wait_status(1, POLL_LIMIT, "data_rcvd");
   endtask

   // replays the last monitored frame on the receive pins
   task automatic drive_frame(input int bad_idx, input logic [3:0] flip);
      for (int i = 0; i < mon_q.size(); i++) begin
         @(posedge clk);
         drv_dv <= 1'b1;
         drv_data <= (i == bad_idx) ? (mon_q[i] ^ flip) : mon_q[i];
      end
      @(posedge clk);
      drv_dv <= 1'b0;
      drv_data <= 4'h0;
   endtask

   task automatic ack_frame();
      logic [31:0] st;
      host_write(`ETH_RCVACK, 32'd1);
      host_read(`ETH_STATUS, st);
      compare_word("status.data_rcvd", st[1], 0);
   endtask

   task automatic check_default_counts();
      logic [31:0] st;
      send_frame(`ETH_NBYTES_RST, 1'b0);
      compare_word("tx_en cycles", mon_q.size(), 16 + 2 * `ETH_NBYTES_RST + 8);
      host_read(`ETH_STATUS, st);
      compare_word("status.rx_count", st[14:4], `ETH_NBYTES_RST + 4);
      ack_frame();
   endtask

   task automatic end_test(input string name, input int err0);
      tests++;
      if (errors == err0) begin
         tests_ok++;
         $display("%s: ok", name);
      end else begin
         $display("%s: %0d failed checks", name, errors - err0);
      end
   endtask

   task automatic test_reset();
      int err0;
      logic [31:0] st;
      logic [31:0] val;
      err0 = errors;
      host_read(`ETH_STATUS, st);
      compare_word("status.phy_resetn", st[3], 0);
      compare_word("phy_resetn", phy_resetn, 0);
      wait_status(3, `ETH_PHY_RST_CYCLES + 16, "phy_resetn release");
      compare_word("phy_resetn", phy_resetn, 1);
      host_read(`ETH_STATUS, st);
      compare_word("status.ready", st[0], 1);
      val = rand_bits(32);
      host_write(`ETH_SCRATCH, val);
      host_read(`ETH_SCRATCH, st);
      compare_word("scratch", st, val);
      check_default_counts();
      end_test("reset and registers", err0);
   endtask

   task automatic test_loopback();
      int err0;
      int n;
      logic [31:0] rd;
      err0 = errors;
      n = 46 + rand_bits(8) % 155;
      send_frame(n, 1'b1);
      host_read(`ETH_STATUS, rd);
      compare_word("status.rx_count", rd[14:4], n + 4);
      for (int i = 0; i < n; i++) begin
         host_read(eth_reg_addr_t'(12'h800 + i), rd);
         compare_byte("rx_buf byte", rd[7:0], payload[i]);
      end
      host_read(`ETH_CRC, rd);
      compare_crc("crc_value", rd, `ETH_CRC_RESIDUE);
      ack_frame();
      end_test("loopback frame", err0);
   endtask

   task automatic test_tx_stream();
      int err0;
      int n;
      err0 = errors;
      n = 46 + rand_bits(8) % 155;
      send_frame(n, 1'b1);
      compare_word("tx_en cycles", mon_q.size(), 16 + 2 * n + 8);
      if (mon_q.size() >= 16 + 2 * n) begin
         for (int i = 0; i < 15; i++) begin
            compare_byte("tx_data preamble", mon_q[i], 8'h05);
         end
         compare_byte("tx_data sfd", mon_q[15], 8'h0d);
         // low nibble goes out first
         for (int i = 0; i < n; i++) begin
            compare_byte("tx_data payload", {mon_q[17 + 2 * i], mon_q[16 + 2 * i]}, payload[i]);
         end
      end
      ack_frame();
      end_test("transmit stream", err0);
   endtask

   task automatic test_rx_corrupt();
      int err0;
      int k;
      logic [3:0] flip;
      eth_byte_t bad_byte;
      eth_crc_t crc_bad;
      logic [31:0] rd;
      err0 = errors;
      k = rand_bits(8) % frame_len;
      flip = 4'(rand_bits(4));
      flip[0] = 1'b1;
      bad_byte = payload[k] ^ {4'h0, flip};
      @(posedge clk);
      loop_en <= 1'b0;
      drive_frame(16 + 2 * k, flip);
      wait_status(1, POLL_LIMIT, "data_rcvd on corrupted frame");
      host_read(`ETH_CRC, rd);
      crc_bad = rd;
      if (crc_bad === `ETH_CRC_RESIDUE) begin
         $display("corrupted frame left a good crc residue");
         errors++;
      end
      // dropped while data_rcvd is still set
      drive_frame(-1, 4'h0);
      host_read(`ETH_CRC, rd);
      compare_crc("crc_value held", rd, crc_bad);
      host_read(eth_reg_addr_t'(12'h800 + k), rd);
      compare_byte("rx_buf byte held", rd[7:0], bad_byte);
      ack_frame();
      drive_frame(-1, 4'h0);
      wait_status(1, POLL_LIMIT, "data_rcvd after ack");
      host_read(`ETH_CRC, rd);
      compare_crc("crc_value", rd, `ETH_CRC_RESIDUE);
      host_read(eth_reg_addr_t'(12'h800 + k), rd);
      compare_byte("rx_buf byte", rd[7:0], payload[k]);
      host_read(`ETH_STATUS, rd);
      compare_word("status.phy_dv_seen", rd[2], 1);
      ack_frame();
      @(posedge clk);
      loop_en <= 1'b1;
      end_test("receive corrupt and ack", err0);
   endtask

   task automatic test_soft_reset();
      int err0;
      logic [31:0] rd;
      err0 = errors;
      host_write(`ETH_SCRATCH, rand_bits(32));
      // counts moved away from their reset value
      send_frame(47 + rand_bits(8) % 154, 1'b1);
      host_read(`ETH_STATUS, rd);
      compare_word("status.data_rcvd", rd[1], 1);
      host_write(`ETH_SOFTRST, 32'd1);
      host_read(`ETH_STATUS, rd);
      compare_word("status.data_rcvd", rd[1], 0);
      compare_word("status.phy_resetn", rd[3], 0);
      compare_word("phy_resetn", phy_resetn, 0);
      host_read(`ETH_SCRATCH, rd);
      compare_word("scratch", rd, 0);
      wait_status(3, `ETH_PHY_RST_CYCLES + 16, "phy_resetn release after soft reset");
      check_default_counts();
      end_test("soft reset", err0);
   endtask

   initial begin
      rst_int = 1'b1;
      sel = 1'b0;
      we = 1'b0;
      addr = '0;
      data_in = '0;
      loop_en = 1'b1;
      drv_dv = 1'b0;
      drv_data = 4'h0;
      lfsr = 32'h0a1a4586;
      frame_len = 0;
      errors = 0;
      tests = 0;
      tests_ok = 0;
      repeat (3) @(posedge clk);
      rst_int <= 1'b0;
      test_reset();
      test_loopback();
      test_tx_stream();
      test_rx_corrupt();
      test_soft_reset();
      if (dut.u_assert.fail_count != 0) begin
         $display("%0d assertion failures in the bound checker", dut.u_assert.fail_count);
         errors += dut.u_assert.fail_count;
      end
      $display("%0d tests, %0d clean, %0d failed checks", tests, tests_ok, errors);
      if (errors == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== eth_assert.sv ====
`default_nettype none

module eth_assert (
   input wire clk,
   input wire rst_int,
   input wire send,
   input wire rcv_ack,
   input wire tx_en,
   input wire phy_resetn,
   input wire [31:0] data_out
);

   int fail_count = 0;

   // strobes are single cycle
   send_pulse: assert property (@(posedge clk) disable iff (rst_int) send |=> !send)
      else begin
         fail_count++;
         $error("send high for two cycles");
      end

   ack_pulse: assert property (@(posedge clk) disable iff (rst_int) rcv_ack |=> !rcv_ack)
      else begin
         fail_count++;
         $error("rcv_ack high for two cycles");
      end

   // no frame while the phy is held in reset
   tx_gate: assert property (@(posedge clk) !phy_resetn |-> !tx_en)
      else begin
         fail_count++;
         $error("tx_en high while phy_resetn is low");
      end

   rd_clear: assert property (@(posedge clk) rst_int |=> data_out == 32'd0)
      else begin
         fail_count++;
         $error("data_out not zero after reset");
      end

endmodule

bind eth_core eth_assert u_assert (
   .clk(clk),
   .rst_int(rst_int),
   .send(send),
   .rcv_ack(rcv_ack),
   .tx_en(tx_en),
   .phy_resetn(phy_resetn),
   .data_out(data_out)
);

`default_nettype wire

// ==== eth_core.sv ====
`default_nettype none

module eth_core
   import eth_pkg::*;
(
   input wire clk,
   input wire rst_int,
   input wire sel,
   input wire we,
   input wire eth_reg_addr_t addr,
   input wire [31:0] data_in,
   output logic [31:0] data_out,
   output logic tx_en,
   output logic [3:0] tx_data,
   input wire rx_dv,
   input wire [3:0] rx_data,
   output logic phy_resetn
);

   logic core_rst;
   logic soft_rst;
   logic send;
   logic rcv_ack;
   logic ready;
   logic data_rcvd;
   logic phy_dv_seen;
   eth_nbytes_t tx_nbytes;
   eth_nbytes_t rx_nbytes;
   eth_nbytes_t rx_count;
   eth_crc_t crc_value;
   logic tx_buf_we;
   eth_buf_addr_t buf_addr;
   eth_byte_t tx_buf_wdata;
   eth_byte_t rx_buf_rdata;
   eth_buf_addr_t tx_rd_addr;
   eth_byte_t tx_rd_data;
   logic rx_wr;
   eth_buf_addr_t rx_wr_addr;
   eth_byte_t rx_wr_data;

   assign core_rst = rst_int | soft_rst;

   eth_regs u_regs (
      .clk(clk),
      .rst_int(rst_int),
      .sel(sel),
      .we(we),
      .addr(addr),
      .data_in(data_in),
      .ready(ready),
      .data_rcvd(data_rcvd),
      .rx_count(rx_count),
      .crc_value(crc_value),
      .rx_buf_rdata(rx_buf_rdata),
      .phy_resetn(phy_resetn),
      .phy_dv_seen(phy_dv_seen),
      .data_out(data_out),
      .send(send),
      .rcv_ack(rcv_ack),
      .soft_rst(soft_rst),
      .tx_nbytes(tx_nbytes),
      .rx_nbytes(rx_nbytes),
      .tx_buf_we(tx_buf_we),
      .buf_addr(buf_addr),
      .tx_buf_wdata(tx_buf_wdata)
   );

   eth_phy_rst u_phy_rst (
      .clk(clk),
      .rst_int(core_rst),
      .rx_dv(rx_dv),
      .phy_resetn(phy_resetn),
      .phy_dv_seen(phy_dv_seen)
   );

   // host fills it, transmitter reads it
   eth_dp_ram tx_buf (
      .clk(clk),
      .we(tx_buf_we),
      .wr_addr(buf_addr),
      .wr_data(tx_buf_wdata),
      .rd_addr(tx_rd_addr),
      .rd_data(tx_rd_data)
   );

   eth_dp_ram rx_buf (
      .clk(clk),
      .we(rx_wr),
      .wr_addr(rx_wr_addr),
      .wr_data(rx_wr_data),
      .rd_addr(buf_addr),
      .rd_data(rx_buf_rdata)
   );

   eth_tx u_tx (
      .clk(clk),
      .rst_int(core_rst),
      .send(send),
      .nbytes(tx_nbytes),
      .phy_resetn(phy_resetn),
      .rd_data(tx_rd_data),
      .ready(ready),
      .rd_addr(tx_rd_addr),
      .tx_en(tx_en),
      .tx_data(tx_data)
   );

   eth_rx u_rx (
      .clk(clk),
      .rst_int(core_rst),
      .rcv_ack(rcv_ack),
      .nbytes(rx_nbytes),
      .rx_dv(rx_dv),
      .rx_data(rx_data),
      .wr(rx_wr),
      .wr_addr(rx_wr_addr),
      .wr_data(rx_wr_data),
      .data_rcvd(data_rcvd),
      .rx_count(rx_count),
      .crc_value(crc_value)
   );

endmodule

`default_nettype wire

// ==== eth_rx.sv ====
`default_nettype none

module eth_rx
   import eth_pkg::*;
(
   input wire clk,
   input wire rst_int,
   input wire rcv_ack,
   input wire eth_nbytes_t nbytes,
   input wire rx_dv,
   input wire [3:0] rx_data,
   output logic wr,
   output eth_buf_addr_t wr_addr,
   output eth_byte_t wr_data,
   output logic data_rcvd,
   output eth_nbytes_t rx_count,
   output eth_crc_t crc_value
);

   typedef enum logic [1:0] {S_HUNT, S_PRE, S_DATA, S_DONE} rx_state_t;

   rx_state_t state;
   logic dv_q;
   logic [3:0] data_q;
   logic [3:0] lo;
   logic nib_hi;
   logic last_byte;
   logic crc_init;
   logic crc_en;
   eth_crc_t crc;
   eth_crc_t crc_rev;

   // frame complete after nbytes plus the fcs
   assign last_byte = ({1'b0, rx_count} + 12'd1) == ({1'b0, nbytes} + 12'd4);

   assign crc_init = (state == S_PRE);
   assign crc_en = (state == S_DATA) && dv_q;

   eth_crc32 u_crc (
      .clk(clk),
      .rst_int(rst_int),
      .init(crc_init),
      .en(crc_en),
      .nibble(data_q),
      .crc(crc)
   );

   // back to register order, a good frame leaves the residue
   assign crc_rev = {<<{crc}};
   assign crc_value = ~crc_rev;

   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int) begin
         state <= S_HUNT;
         dv_q <= 1'b0;
         nib_hi <= 1'b0;
         wr <= 1'b0;
         rx_count <= '0;
         data_rcvd <= 1'b0;
      end else begin
         dv_q <= rx_dv;
         wr <= 1'b0;
         case (state)
            S_HUNT: begin
               if (dv_q && data_q == 4'h5) begin
                  state <= S_PRE;
               end
            end
            S_PRE: begin
               if (!dv_q) begin
                  state <= S_HUNT;
               end else if (data_q == 4'hD) begin
                  state <= S_DATA;
                  nib_hi <= 1'b0;
                  rx_count <= '0;
               end else if (data_q != 4'h5) begin
                  state <= S_HUNT;
               end
            end
            S_DATA: begin
               // dv dropped early, keep what was written
               if (!dv_q) begin
                  state <= S_HUNT;
               end else if (!nib_hi) begin
                  nib_hi <= 1'b1;
               end else begin
                  nib_hi <= 1'b0;
                  wr <= 1'b1;
                  rx_count <= rx_count + 1'b1;
                  if (last_byte) begin
                     state <= S_DONE;
                  end
               end
            end
            S_DONE: begin
               // frames are ignored until the host acks
               if (data_rcvd && rcv_ack) begin
                  data_rcvd <= 1'b0;
                  state <= S_HUNT;
               end else if (wr) begin
                  data_rcvd <= 1'b1;
               end
            end
            default: state <= S_HUNT;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      data_q <= rx_data;
      if (state == S_DATA && !nib_hi) begin
         lo <= data_q;
      end
      if (state == S_DATA && nib_hi) begin
         wr_data <= {data_q, lo};
         wr_addr <= eth_buf_addr_t'(rx_count);
      end
   end

endmodule

`default_nettype wire

// ==== eth_tx.sv ====
`default_nettype none

module eth_tx
   import eth_pkg::*;
(
   input wire clk,
   input wire rst_int,
   input wire send,
   input wire eth_nbytes_t nbytes,
   input wire phy_resetn,
   input wire eth_byte_t rd_data,
   output logic ready,
   output eth_buf_addr_t rd_addr,
   output logic tx_en,
   output logic [3:0] tx_data
);

   typedef enum logic [1:0] {S_IDLE, S_PRE, S_DATA, S_FCS} tx_state_t;

   tx_state_t state;
   logic [11:0] cnt;
   logic [11:0] last_nib;
   eth_nbytes_t len;
   logic [3:0] hi;
   logic start;
   logic crc_init;
   logic crc_en;
   logic [3:0] crc_nib;
   eth_crc_t crc;

   assign start = (state == S_IDLE) && send && ready;
   assign last_nib = {len, 1'b0} - 12'd1;

   // crc follows the payload nibbles as they go out
   assign crc_init = (state == S_IDLE);
   assign crc_en = (state == S_DATA);
   assign crc_nib = cnt[0] ? hi : rd_data[3:0];

   eth_crc32 u_crc (
      .clk(clk),
      .rst_int(rst_int),
      .init(crc_init),
      .en(crc_en),
      .nibble(crc_nib),
      .crc(crc)
   );

   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int) begin
         state <= S_IDLE;
         cnt <= '0;
         ready <= 1'b0;
         tx_en <= 1'b0;
         tx_data <= 4'h0;
         rd_addr <= '0;
      end else begin
         case (state)
            S_IDLE: begin
               rd_addr <= '0;
               tx_data <= 4'h0;
               if (start) begin
                  state <= S_PRE;
                  cnt <= '0;
                  tx_en <= 1'b1;
                  tx_data <= 4'h5;
                  ready <= 1'b0;
               end else begin
                  ready <= phy_resetn;
               end
            end
            S_PRE: begin
               cnt <= cnt + 1'b1;
               // 15 preamble nibbles then the sfd
               if (cnt == 12'd14) begin
                  tx_data <= 4'hD;
                  cnt <= '0;
                  state <= (len == '0) ? S_FCS : S_DATA;
               end else begin
                  tx_data <= 4'h5;
               end
            end
            S_DATA: begin
               cnt <= cnt + 1'b1;
               if (!cnt[0]) begin
                  tx_data <= rd_data[3:0];
                  // next byte is on rd_data two cycles later
                  rd_addr <= rd_addr + 1'b1;
               end else begin
                  tx_data <= hi;
               end
               if (cnt == last_nib) begin
                  state <= S_FCS;
                  cnt <= '0;
               end
            end
            S_FCS: begin
               cnt <= cnt + 1'b1;
               if (cnt == 12'd8) begin
                  state <= S_IDLE;
                  tx_en <= 1'b0;
                  tx_data <= 4'h0;
               end else begin
                  tx_data <= crc[{cnt[2:0], 2'b00} +: 4];
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (start) begin
         len <= nbytes;
      end
      if (state == S_DATA && !cnt[0]) begin
         hi <= rd_data[7:4];
      end
   end

endmodule

`default_nettype wire

// ==== eth_phy_rst.sv ====
`default_nettype none

`include "eth_params.svh"

module eth_phy_rst (
   input wire clk,
   input wire rst_int,
   input wire rx_dv,
   output logic phy_resetn,
   output logic phy_dv_seen
);

   localparam int CNT_W = $clog2(`ETH_PHY_RST_CYCLES + 1);

   logic [CNT_W-1:0] cnt;

   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int) begin
         cnt <= '0;
         phy_resetn <= 1'b0;
         phy_dv_seen <= 1'b0;
      end else if (!phy_resetn) begin
         // release on the last count
         if (cnt == CNT_W'(`ETH_PHY_RST_CYCLES - 1)) begin
            phy_resetn <= 1'b1;
         end else begin
            cnt <= cnt + 1'b1;
         end
      end else if (rx_dv) begin
         phy_dv_seen <= 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== eth_regs.sv ====
`default_nettype none

`include "eth_params.svh"

module eth_regs
   import eth_pkg::*;
(
   input wire clk,
   input wire rst_int,
   input wire sel,
   input wire we,
   input wire eth_reg_addr_t addr,
   input wire [31:0] data_in,
   input wire ready,
   input wire data_rcvd,
   input wire eth_nbytes_t rx_count,
   input wire eth_crc_t crc_value,
   input wire eth_byte_t rx_buf_rdata,
   input wire phy_resetn,
   input wire phy_dv_seen,
   output logic [31:0] data_out,
   output logic send,
   output logic rcv_ack,
   output logic soft_rst,
   output eth_nbytes_t tx_nbytes,
   output eth_nbytes_t rx_nbytes,
   output logic tx_buf_we,
   output eth_buf_addr_t buf_addr,
   output eth_byte_t tx_buf_wdata
);

   logic regs_rst;
   logic reg_wr;
   logic rd_en;
   logic [10:0] reg_idx;
   logic [31:0] scratch;
   logic [31:0] reg_mux;
   logic [31:0] rd_word;
   logic rd_buf;

   // soft_rst itself only sees the external reset
   assign regs_rst = rst_int | soft_rst;

   assign reg_idx = addr[10:0];
   assign reg_wr = sel & we & ~addr[11];
   assign rd_en = sel & ~we;

   // buffer window writes go straight to the tx buffer
   assign tx_buf_we = sel & we & addr[11];
   assign buf_addr = eth_buf_addr_t'(addr[10:0]);
   assign tx_buf_wdata = data_in[7:0];

   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int) begin
         soft_rst <= 1'b0;
      end else begin
         soft_rst <= reg_wr && (reg_idx == `ETH_SOFTRST) && !soft_rst;
      end
   end

   // self-clearing strobes, a back-to-back write is dropped
   always_ff @(posedge clk or posedge regs_rst) begin
      if (regs_rst) begin
         send <= 1'b0;
         rcv_ack <= 1'b0;
      end else begin
         send <= reg_wr && (reg_idx == `ETH_SEND) && !send;
         rcv_ack <= reg_wr && (reg_idx == `ETH_RCVACK) && !rcv_ack;
      end
   end

   always_ff @(posedge clk or posedge regs_rst) begin
      if (regs_rst) begin
         scratch <= '0;
         tx_nbytes <= eth_nbytes_t'(`ETH_NBYTES_RST);
         rx_nbytes <= eth_nbytes_t'(`ETH_NBYTES_RST);
      end else if (reg_wr) begin
         case (reg_idx)
            `ETH_SCRATCH: scratch <= data_in;
            `ETH_TX_NBYTES: tx_nbytes <= data_in[10:0];
            `ETH_RX_NBYTES: rx_nbytes <= data_in[10:0];
            default: ;
         endcase
      end
   end

   always_comb begin
      case (reg_idx)
         `ETH_STATUS: reg_mux = {17'd0, rx_count, phy_resetn, phy_dv_seen, data_rcvd, ready};
         `ETH_SCRATCH: reg_mux = scratch;
         `ETH_CRC: reg_mux = crc_value;
         default: reg_mux = '0;
      endcase
   end

   // buffer byte shows up a cycle after the read, then gets held here
   always_ff @(posedge clk or posedge regs_rst) begin
      if (regs_rst) begin
         rd_word <= '0;
         rd_buf <= 1'b0;
      end else if (rd_en) begin
         rd_word <= addr[11] ? 32'd0 : reg_mux;
         rd_buf <= addr[11];
      end else if (rd_buf) begin
         rd_word <= {24'd0, rx_buf_rdata};
         rd_buf <= 1'b0;
      end
   end

   assign data_out = rd_buf ? {24'd0, rx_buf_rdata} : rd_word;

endmodule

`default_nettype wire

// ==== eth_crc32.sv ====
`default_nettype none

module eth_crc32
   import eth_pkg::*;
(
   input wire clk,
   input wire rst_int,
   input wire init,
   input wire en,
   input wire [3:0] nibble,
   output eth_crc_t crc
);

   localparam eth_crc_t POLY = 32'hEDB88320;

   eth_crc_t state;

   // reflected update, bit 0 of the nibble goes in first
   function automatic eth_crc_t crc_step(eth_crc_t c, logic [3:0] d);
      eth_crc_t r;
      r = c;
      for (int i = 0; i < 4; i++) begin
         r = (r >> 1) ^ ((r[0] ^ d[i]) ? POLY : 32'h0);
      end
      return r;
   endfunction

   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int) begin
         state <= '1;
      end else if (init) begin
         state <= '1;
      end else if (en) begin
         state <= crc_step(state, nibble);
      end
   end

   // fcs as sent, crc[3:0] is the first nibble on the wire
   assign crc = ~state;

endmodule

`default_nettype wire

// ==== eth_dp_ram.sv ====
`default_nettype none

`include "eth_params.svh"

module eth_dp_ram
   import eth_pkg::*;
(
   input wire clk,
   input wire we,
   input wire eth_buf_addr_t wr_addr,
   input wire eth_byte_t wr_data,
   input wire eth_buf_addr_t rd_addr,
   output eth_byte_t rd_data
);

   eth_byte_t mem [`ETH_BUF_DEPTH];

   always_ff @(posedge clk) begin
      if (we) begin
         mem[wr_addr] <= wr_data;
      end
   end

   // read data valid the cycle after the address
   always_ff @(posedge clk) begin
      rd_data <= mem[rd_addr];
   end

endmodule

`default_nettype wire

// ==== eth_pkg.sv ====
`default_nettype none

`include "eth_params.svh"

package eth_pkg;

   // one payload byte
   typedef logic [7:0] eth_byte_t;

   // frame length in bytes
   typedef logic [10:0] eth_nbytes_t;

   typedef logic [$clog2(`ETH_BUF_DEPTH)-1:0] eth_buf_addr_t;

   // bit 11 selects the buffer window
   typedef logic [`ETH_ADDR_W-1:0] eth_reg_addr_t;

   typedef logic [31:0] eth_crc_t;

endpackage

`default_nettype wire

// ==== eth_params.svh ====
`ifndef ETH_PARAMS_SVH
`define ETH_PARAMS_SVH

// host address width, bit 11 selects the buffer window
`define ETH_ADDR_W 12

`define ETH_BUF_DEPTH 2048

// register map
`define ETH_STATUS    0
`define ETH_SEND      1
`define ETH_RCVACK    2
`define ETH_SCRATCH   3
`define ETH_TX_NBYTES 4
`define ETH_RX_NBYTES 5
`define ETH_SOFTRST   6
`define ETH_CRC       7

`define ETH_NBYTES_RST 46
`define ETH_PHY_RST_CYCLES 64

// crc over a good frame plus its fcs
`define ETH_CRC_RESIDUE 32'hC704DD7B

`endif
